/* hw/adxl_defs.svh */
`ifndef ADXL_DEFS_SVH
`define ADXL_DEFS_SVH

// registers 0x00..0x39 fetched per transaction
`define ADXL_REG_COUNT  8'h3A

// host word geometry
`define ADXL_LANES      4
`define ADXL_WORDS      16
`define ADXL_WORD_AW    4

// byte position inside one read burst
`define ADXL_IDX_W      6

// pointer write carries one byte
`define ADXL_PTR_LEN    8'h01

// first register of the burst
`define ADXL_START_REG  8'h00

`endif

/* hw/adxl_pkg.sv */
`include "adxl_defs.svh"

package adxl_pkg;

    typedef logic [7:0] byte_t;                        // one data or command byte

    typedef logic [`ADXL_WORD_AW-1:0] word_addr_t;     // host word address

    typedef logic [`ADXL_IDX_W-1:0] byte_idx_t;        // byte number in a burst

    // command sequencer states
    typedef enum logic [2:0] {
        idle,       // waiting for a request
        tx_len,     // pointer write length byte
        tx_ptr,     // register pointer byte
        tx_read,    // read length byte
        rx_data     // collecting register bytes
    } seq_state_t;

endpackage

/* hw/adxl_request_timer.sv */
`timescale 1ns/1ps

module adxl_request_timer (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        interval_enable,
    input  logic [31:0] interval_cycles,
    input  logic        single_request,
    input  logic        busy,
    output logic        req,
    output logic        req_single
);

    logic [31:0] count;       // interval down-counter
    logic        pending;     // single request waiting for idle
    logic        fire;

    // req itself blocks a second pulse before busy rises
    assign fire = !busy && !req && (pending || (interval_enable && count == 32'd0));

    always_ff @(posedge CLK) begin
        if (RESET) begin
            req        <= 1'b0;
            req_single <= 1'b0;
            pending    <= 1'b0;
        end else begin
            req        <= fire;
            req_single <= fire && pending;
            if (fire && pending) begin
                pending <= single_request;         // new pulse stays queued
            end else if (single_request) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            count <= '0;
        end else if (busy || !interval_enable || fire) begin
            count <= interval_cycles;              // reload outside idle countdown
        end else if (count != 32'd0) begin
            count <= count - 32'd1;
        end
    end

    // the sequencer only looks at req in idle
    a_req_idle: assert property (
        @(posedge CLK) disable iff (RESET)
        $rose(req) |-> !busy
    ) else $error("request raised while sequencer busy");

endmodule

/* hw/adxl_cmd_sequencer.sv */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_cmd_sequencer (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req,
    input  logic                    req_single,
    input  logic [6:0]              i2c_address,
    output logic                    busy,
    output logic                    done,
    output logic                    single_done,
    output adxl_pkg::byte_t         m_axis_tdata,
    output logic [7:0]              m_axis_tuser,
    output logic                    m_axis_tvalid,
    output logic                    m_axis_tlast,
    input  logic                    m_axis_tready,
    input  adxl_pkg::byte_t         s_axis_tdata,
    input  logic                    s_axis_tvalid,
    input  logic                    s_axis_tlast,
    output logic                    s_axis_tready,
    output logic [`ADXL_LANES-1:0]  lane_wren,
    output adxl_pkg::word_addr_t    lane_addr,
    output adxl_pkg::byte_t         lane_data
);

    import adxl_pkg::*;

    seq_state_t state;
    byte_idx_t  idx;          // next byte number in the burst
    logic [6:0] addr_q;       // device address for this transaction
    logic       single_q;     // transaction started by a single request
    logic       rx_fire;
    logic       tx_fire;

    assign busy          = (state != idle);
    assign s_axis_tready = (state == rx_data);
    assign rx_fire       = s_axis_tvalid && s_axis_tready;
    assign tx_fire       = m_axis_tvalid && m_axis_tready;
    assign single_done   = done && single_q;

    // command byte is a pure decode of the state
    always_comb begin
        m_axis_tvalid = 1'b0;
        m_axis_tlast  = 1'b0;
        m_axis_tdata  = 8'h00;
        case (state)
            tx_len: begin
                m_axis_tvalid = 1'b1;
                m_axis_tdata  = `ADXL_PTR_LEN;
            end
            tx_ptr: begin
                m_axis_tvalid = 1'b1;
                m_axis_tlast  = 1'b1;              // ends pointer write
                m_axis_tdata  = `ADXL_START_REG;
            end
            tx_read: begin
                m_axis_tvalid = 1'b1;
                m_axis_tlast  = 1'b1;
                m_axis_tdata  = `ADXL_REG_COUNT;
            end
            default: begin
                m_axis_tvalid = 1'b0;
            end
        endcase
    end

    // bit 0 set only for the read command
    assign m_axis_tuser = {addr_q, state == tx_read};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= idle;
            idx      <= '0;
            single_q <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (req) begin
                        state    <= tx_len;
                        single_q <= req_single;
                    end
                end
                tx_len: begin
                    if (tx_fire) state <= tx_ptr;
                end
                tx_ptr: begin
                    if (tx_fire) state <= tx_read;
                end
                tx_read: begin
                    if (tx_fire) begin
                        state <= rx_data;
                        idx   <= '0;
                    end
                end
                rx_data: begin
                    if (rx_fire) begin
                        idx <= idx + 1'b1;
                        if (s_axis_tlast) begin
                            state <= idle;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == idle && req) begin
            addr_q <= i2c_address;
        end
    end

    // byte k goes to lane k mod 4, word k div 4
    always_ff @(posedge CLK) begin
        if (RESET) begin
            lane_wren <= '0;
        end else begin
            lane_wren <= rx_fire ? (`ADXL_LANES'(1) << idx[1:0]) : '0;
        end
    end

    always_ff @(posedge CLK) begin
        lane_addr <= idx[`ADXL_IDX_W-1:2];
        lane_data <= s_axis_tdata;
    end

    a_tx_stable: assert property (
        @(posedge CLK) disable iff (RESET)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tuser)
             && $stable(m_axis_tlast))
    ) else $error("command byte changed under back-pressure");

    // device must close the burst with tlast in time
    a_idx_range: assert property (
        @(posedge CLK) disable iff (RESET)
        rx_fire |-> (idx < `ADXL_REG_COUNT)
    ) else $error("read burst longer than register count");

endmodule

/* hw/adxl_lane_bank.sv */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_lane_bank (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wren,
    input  adxl_pkg::word_addr_t  waddr,
    input  adxl_pkg::byte_t       wdata,
    input  adxl_pkg::word_addr_t  raddr,
    output adxl_pkg::byte_t       rdata
);

    import adxl_pkg::*;

    byte_t mem [`ADXL_WORDS];     // one byte of each host word

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < `ADXL_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wren) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];    // combinational read

endmodule

/* hw/adxl_host_read.sv */
`timescale 1ns/1ps

module adxl_host_read (
    input  logic                  CLK,
    input  logic                  RESET,
    input  adxl_pkg::word_addr_t  raddr,
    input  logic [31:0]           lane_rdata,
    output adxl_pkg::word_addr_t  lane_raddr,
    output logic [31:0]           rdata
);

    // all lanes share one read address
    assign lane_raddr = raddr;

    // lane k already sits in bits 8k+7..8k
    always_ff @(posedge CLK) begin
        if (RESET) begin
            rdata <= '0;
        end else begin
            rdata <= lane_rdata;                  // one cycle read latency
        end
    end

    a_raddr_known: assert property (
        @(posedge CLK) disable iff (RESET)
        !$isunknown(raddr)
    ) else $error("host read address unknown");

endmodule

/* hw/adxl345_reader.sv */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl345_reader (
    input  logic                  CLK,
    input  logic                  RESET,
    input  adxl_pkg::word_addr_t  raddr,
    output logic [31:0]           rdata,
    input  logic [6:0]            i2c_address,
    input  logic                  interval_enable,
    input  logic [31:0]           interval_cycles,
    input  logic                  single_request,
    output logic                  single_done,
    output adxl_pkg::byte_t       m_axis_tdata,
    output logic [7:0]            m_axis_tuser,
    output logic                  m_axis_tvalid,
    output logic                  m_axis_tlast,
    input  logic                  m_axis_tready,
    input  adxl_pkg::byte_t       s_axis_tdata,
    input  logic                  s_axis_tvalid,
    input  logic                  s_axis_tlast,
    output logic                  s_axis_tready
);

    import adxl_pkg::*;

    logic                    req;
    logic                    req_single;
    logic                    busy;
    logic [`ADXL_LANES-1:0]  lane_wren;
    word_addr_t              lane_addr;
    byte_t                   lane_data;
    word_addr_t              lane_raddr;
    logic [31:0]             lane_rdata;

    adxl_request_timer u_timer (
        .CLK(CLK), .RESET(RESET),
        .interval_enable(interval_enable), .interval_cycles(interval_cycles),
        .single_request(single_request), .busy(busy),
        .req(req), .req_single(req_single)
    );

    adxl_cmd_sequencer u_seq (
        .CLK(CLK), .RESET(RESET),
        .req(req), .req_single(req_single), .i2c_address(i2c_address),
        .busy(busy), .done(), .single_done(single_done),
        .m_axis_tdata(m_axis_tdata), .m_axis_tuser(m_axis_tuser),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tlast(m_axis_tlast),
        .m_axis_tready(m_axis_tready),
        .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tlast(s_axis_tlast), .s_axis_tready(s_axis_tready),
        .lane_wren(lane_wren), .lane_addr(lane_addr), .lane_data(lane_data)
    );

    for (genvar g = 0; g < `ADXL_LANES; g++) begin : g_lane
        adxl_lane_bank u_lane (
            .CLK(CLK), .RESET(RESET),
            .wren(lane_wren[g]), .waddr(lane_addr), .wdata(lane_data),
            .raddr(lane_raddr), .rdata(lane_rdata[8*g +: 8])
        );
    end

    adxl_host_read u_host (
        .CLK(CLK), .RESET(RESET),
        .raddr(raddr), .lane_rdata(lane_rdata),
        .lane_raddr(lane_raddr), .rdata(rdata)
    );

endmodule

/* verif/adxl_device_model.sv */
`timescale 1ns/1ps

module adxl_device_model (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         stall_en,
    input  logic [7:0]   m_axis_tdata,
    input  logic [7:0]   m_axis_tuser,
    input  logic         m_axis_tvalid,
    input  logic         m_axis_tlast,
    output logic         m_axis_tready,
    output logic [7:0]   s_axis_tdata,
    output logic         s_axis_tvalid,
    output logic         s_axis_tlast,
    input  logic         s_axis_tready,
    output logic [23:0]  cmd_data_log,
    output logic [23:0]  cmd_user_log,
    output logic [2:0]   cmd_last_log,
    output logic [31:0]  cmd_total,
    output logic [31:0]  xact_count,
    output logic [511:0] image
);

    localparam int BURST = 58;

    logic [31:0] rng;
    logic [7:0]  burst [BURST];
    int          cmd_cnt;        // command bytes seen in this transaction
    int          rx_pos;         // next read byte to offer
    logic        sending;
    logic        s_taken;        // offered byte goes across on the next rising edge

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rng = 32'hfd4648a8;
        m_axis_tready = 1'b0;
        s_axis_tdata = 8'h00;
        s_axis_tvalid = 1'b0;
        s_axis_tlast = 1'b0;
        cmd_data_log = '0;
        cmd_user_log = '0;
        cmd_last_log = '0;
        cmd_total = '0;
        xact_count = '0;
        image = '0;
    end

    // bus outputs of the DUT are settled by the falling edge
    always @(negedge CLK) begin
        if (RESET) begin
            m_axis_tready = 1'b0;
            s_axis_tvalid = 1'b0;
            s_axis_tlast = 1'b0;
            sending = 1'b0;
            s_taken = 1'b0;
            cmd_cnt = 0;
            rx_pos = 0;
        end else begin
            rng = xorshift(rng);
            m_axis_tready = !stall_en || (rng[1:0] != 2'b00);   // 25% stalls
            if (m_axis_tvalid && m_axis_tready) begin
                if (cmd_cnt < 3) begin
                    cmd_data_log[8*cmd_cnt +: 8] = m_axis_tdata;
                    cmd_user_log[8*cmd_cnt +: 8] = m_axis_tuser;
                    cmd_last_log[cmd_cnt] = m_axis_tlast;
                end
                cmd_cnt++;
                cmd_total++;
                if (cmd_cnt == 3) begin                         // read command taken
                    for (int i = 0; i < BURST; i++) begin
                        rng = xorshift(rng);
                        burst[i] = rng[15:8];
                    end
                    sending = 1'b1;
                    rx_pos = 0;
                end
            end
            if (s_taken) begin
                s_axis_tvalid = 1'b0;
                s_axis_tlast = 1'b0;
                s_taken = 1'b0;
            end
            // gaps only while nothing is offered
            if (sending && !s_axis_tvalid && !(stall_en && rng[4:2] < 3'd3)) begin
                s_axis_tvalid = 1'b1;
                s_axis_tdata = burst[rx_pos];
                s_axis_tlast = (rx_pos == BURST - 1);
            end
            if (s_axis_tvalid && s_axis_tready) begin
                s_taken = 1'b1;
                rx_pos++;
                if (rx_pos == BURST) begin
                    sending = 1'b0;
                    cmd_cnt = 0;
                    image = '0;
                    for (int i = 0; i < BURST; i++) begin
                        image[8*i +: 8] = burst[i];
                    end
                    xact_count++;
                end
            end
        end
    end

endmodule

/* verif/adxl_tb.sv */
`timescale 1ns/1ps

module adxl_tb;

    localparam int         TIMEOUT_CYCLES = 4 * 400;
    localparam int         REG_COUNT = 58;
    localparam logic [6:0] DEV_ADDR = 7'h53;
    localparam logic [23:0] CMD_BYTES = {8'h3A, 8'h00, 8'h01};   // byte 0 in the low bits

    logic         CLK;
    logic         RESET;
    logic [3:0]   raddr;
    logic [31:0]  rdata;
    logic [6:0]   i2c_address;
    logic         interval_enable;
    logic [31:0]  interval_cycles;
    logic         single_request;
    logic         single_done;
    logic [7:0]   m_axis_tdata;
    logic [7:0]   m_axis_tuser;
    logic         m_axis_tvalid;
    logic         m_axis_tlast;
    logic         m_axis_tready;
    logic [7:0]   s_axis_tdata;
    logic         s_axis_tvalid;
    logic         s_axis_tlast;
    logic         s_axis_tready;
    logic         stall_en;
    logic [23:0]  cmd_data_log;
    logic [23:0]  cmd_user_log;
    logic [2:0]   cmd_last_log;
    logic [31:0]  cmd_total;
    logic [31:0]  xact_count;
    logic [511:0] image;
    int           errors = 0;
    int           checks = 0;
    int           cycles = 0;
    int           sd_count = 0;
    int           seen_xact = 0;

    adxl345_reader dut0 (
        .CLK(CLK), .RESET(RESET), .raddr(raddr), .rdata(rdata),
        .i2c_address(i2c_address), .interval_enable(interval_enable),
        .interval_cycles(interval_cycles), .single_request(single_request),
        .single_done(single_done),
        .m_axis_tdata(m_axis_tdata), .m_axis_tuser(m_axis_tuser),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tlast(m_axis_tlast),
        .m_axis_tready(m_axis_tready),
        .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tlast(s_axis_tlast), .s_axis_tready(s_axis_tready)
    );

    adxl_device_model model0 (
        .CLK(CLK), .RESET(RESET), .stall_en(stall_en),
        .m_axis_tdata(m_axis_tdata), .m_axis_tuser(m_axis_tuser),
        .m_axis_tvalid(m_axis_tvalid), .m_axis_tlast(m_axis_tlast),
        .m_axis_tready(m_axis_tready),
        .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
        .s_axis_tlast(s_axis_tlast), .s_axis_tready(s_axis_tready),
        .cmd_data_log(cmd_data_log), .cmd_user_log(cmd_user_log),
        .cmd_last_log(cmd_last_log), .cmd_total(cmd_total),
        .xact_count(xact_count), .image(image)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // byte 4w+k of the burst lands in bits 8k+7..8k of word w
    function automatic logic [31:0] expected_word(input logic [3:0] waddr,
                                                  input logic [511:0] img);
        logic [31:0] w;
        int          idx;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            idx = 4 * waddr + k;
            if (idx < REG_COUNT) begin
                w[8*k +: 8] = img[8*idx +: 8];
            end
        end
        return w;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
        @(negedge CLK);
        raddr = addr;
        @(negedge CLK);
        data = rdata;                       // one cycle read latency
    endtask

    task automatic check_image(input logic [511:0] img);
        logic [31:0] data;
        for (int w = 0; w < 16; w++) begin
            read_word(4'(w), data);
            compare_value($sformatf("rdata word %0d", w), data, expected_word(4'(w), img));
        end
    endtask

    task automatic run_single();
        int sd_before;
        int x_before;
        @(posedge CLK);
        sd_before = sd_count;
        x_before = xact_count;
        @(negedge CLK);
        single_request = 1'b1;
        @(negedge CLK);
        single_request = 1'b0;
        while (sd_count == sd_before) begin
            @(posedge CLK);
        end
        repeat (10) @(posedge CLK);
        compare_value("single_done pulses", sd_count - sd_before, 1);
        compare_value("transactions", xact_count - x_before, 1);
        check_image(image);
    endtask

    always @(negedge CLK) begin
        if (!RESET && single_done) begin
            sd_count++;
        end
    end

    // command bytes of every finished transaction
    always @(posedge CLK) begin
        if (xact_count != seen_xact) begin
            seen_xact = xact_count;
            for (int i = 0; i < 3; i++) begin
                compare_value($sformatf("m_axis_tdata byte %0d", i),
                              cmd_data_log[8*i +: 8], CMD_BYTES[8*i +: 8]);
                compare_value($sformatf("m_axis_tuser byte %0d", i),
                              cmd_user_log[8*i +: 8], {DEV_ADDR, i == 2});
                compare_value($sformatf("m_axis_tlast byte %0d", i), cmd_last_log[i], i != 0);
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a transaction never finished", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        int x_before;
        int sd_before;
        int cmd_before;
        RESET = 1'b1;
        raddr = '0;
        i2c_address = DEV_ADDR;
        interval_enable = 1'b0;
        interval_cycles = '0;
        single_request = 1'b0;
        stall_en = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        compare_value("m_axis_tvalid", m_axis_tvalid, 0);
        compare_value("s_axis_tready", s_axis_tready, 0);
        compare_value("single_done", single_done, 0);
        check_image('0);

        run_single();
        stall_en = 1'b1;                    // back-pressure on both streams
        run_single();
        stall_en = 1'b0;

        @(posedge CLK);
        x_before = xact_count;
        sd_before = sd_count;
        @(negedge CLK);
        interval_cycles = 32'd20;
        interval_enable = 1'b1;
        while (xact_count < x_before + 2) begin
            @(posedge CLK);
        end
        @(negedge CLK);
        interval_enable = 1'b0;
        repeat (30) @(posedge CLK);
        compare_value("single_done pulses", sd_count - sd_before, 0);
        check_image(image);

        @(posedge CLK);
        cmd_before = cmd_total;
        repeat (200) @(posedge CLK);
        compare_value("command bytes while idle", cmd_total - cmd_before, 0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/adxl_pkg.sv
hw/adxl_request_timer.sv
hw/adxl_cmd_sequencer.sv
hw/adxl_lane_bank.sv
hw/adxl_host_read.sv
hw/adxl345_reader.sv
verif/adxl_device_model.sv
verif/adxl_tb.sv

/* Bender.yml */
package:
  name: adxl345_reader

sources:
  - include_dirs:
      - hw
    files:
      - hw/adxl_pkg.sv
      - hw/adxl_request_timer.sv
      - hw/adxl_cmd_sequencer.sv
      - hw/adxl_lane_bank.sv
      - hw/adxl_host_read.sv
      - hw/adxl345_reader.sv
  - target: test
    files:
      - verif/adxl_device_model.sv
      - verif/adxl_tb.sv
